//--- design/prc_regs_pkg.sv
`default_nettype none

package prc_regs_pkg;

    // cpu register map
    localparam logic [23:0] reg_mode_addr         = 24'h002080;
    localparam logic [23:0] reg_rate_addr         = 24'h002081;
    localparam logic [23:0] reg_map_base_lo_addr  = 24'h002082;
    localparam logic [23:0] reg_map_base_mid_addr = 24'h002083;
    localparam logic [23:0] reg_map_base_hi_addr  = 24'h002084;
    localparam logic [23:0] reg_scroll_y_addr     = 24'h002085;
    localparam logic [23:0] reg_scroll_x_addr     = 24'h002086;
    localparam logic [23:0] reg_counter_addr      = 24'h00208A;

    localparam int mode_width     = 6;
    localparam int rate_sel_width = 3;
    localparam int map_base_width = 21;
    localparam int scroll_width   = 7;
    localparam int count_width    = 7;
    localparam int skip_width     = 4;

    typedef struct packed {
        logic [mode_width-1:0]     mode;         // bit 1 map enable, bits 5:4 map size
        logic [rate_sel_width-1:0] rate_sel;
        logic [map_base_width-1:0] map_base;
        logic [scroll_width-1:0]   scroll_y;
        logic [scroll_width-1:0]   scroll_x;
        logic                      rate_changed; // single cycle
    } prc_config_t;

    // map size in tiles, indexed by mode bits 5:4
    localparam logic [3:0][4:0] map_width_of  = {5'd24, 5'd24, 5'd16, 5'd12};
    localparam logic [3:0][4:0] map_height_of = {5'd16, 5'd8, 5'd12, 5'd16};

endpackage

`default_nettype wire

//--- design/prc_video_pkg.sv
`default_nettype none

package prc_video_pkg;

    localparam int addr_width = 24;
    localparam int data_width = 8;

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [data_width-1:0] data_t;

    // lcd geometry, one vram byte is an 8 pixel column of a page
    localparam int screen_columns = 96;
    localparam int screen_pages   = 8;

    localparam addr_t vram_base    = 24'h001000;
    localparam addr_t tilemap_base = 24'h001360;

    localparam int frame_ticks        = 66;
    localparam int render_start_tick  = 24;
    localparam int default_osc_divide = 855;

    // skip count at which a frame is active, per rate select
    localparam logic [7:0][3:0] rate_match_of =
        {4'd7, 4'd5, 4'd3, 4'd1, 4'd11, 4'd8, 4'd5, 4'd2};

endpackage

`default_nettype wire

//--- design/prc_mem_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface prc_mem_bus_if;

    logic                 valid;
    logic                 ready;    // low holds the current access
    logic                 write;
    prc_video_pkg::addr_t address;
    prc_video_pkg::data_t wdata;
    prc_video_pkg::data_t rdata;    // sampled in the handshake cycle

    modport master (output valid, output write, output address, output wdata,
                    input ready, input rdata);

    // memory side
    modport slave (input valid, input write, input address, input wdata,
                   output ready, output rdata);

endinterface

`default_nettype wire

//--- design/prc_registers.sv
`timescale 1ns/1ps
`default_nettype none

module prc_registers
(
    input  wire                                   clk,
    input  wire                                   reset,
    input  wire                                   bus_write,
    input  wire prc_video_pkg::addr_t             bus_address,
    input  wire prc_video_pkg::data_t             bus_wdata,
    input  wire [prc_regs_pkg::count_width-1:0]   frame_count,
    input  wire [prc_regs_pkg::skip_width-1:0]    skip_count,
    output prc_video_pkg::data_t                  bus_rdata,
    output prc_regs_pkg::prc_config_t             cfg
);

    logic [prc_regs_pkg::mode_width-1:0]       mode_q;
    logic [3:0]                                rate_q;      // bits 3:1 rate select
    logic [prc_regs_pkg::map_base_width-1:3]   map_base_q;  // 8 byte aligned
    logic [prc_regs_pkg::scroll_width-1:0]     scroll_y_q;
    logic [prc_regs_pkg::scroll_width-1:0]     scroll_x_q;
    logic                                      rate_changed;
    prc_video_pkg::data_t                      scroll_y_limit;
    prc_video_pkg::data_t                      scroll_x_limit;

    // largest scroll that keeps the 96x64 window inside the selected map
    assign scroll_y_limit = {prc_regs_pkg::map_height_of[mode_q[5:4]], 3'b000} - 8'd64;
    assign scroll_x_limit = {prc_regs_pkg::map_width_of[mode_q[5:4]], 3'b000} - 8'd96;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            mode_q       <= '0;
            rate_q       <= '0;
            map_base_q   <= '0;
            scroll_y_q   <= '0;
            scroll_x_q   <= '0;
            rate_changed <= 1'b0;
        end
        else
        begin
            rate_changed <= 1'b0;
            if (bus_write)
            begin
                case (bus_address)
                    prc_regs_pkg::reg_mode_addr:
                        mode_q <= bus_wdata[5:0];
                    prc_regs_pkg::reg_rate_addr:
                    begin
                        rate_q       <= bus_wdata[3:0];
                        rate_changed <= (bus_wdata[3:1] != rate_q[3:1]);
                    end
                    prc_regs_pkg::reg_map_base_lo_addr:
                        map_base_q[7:3] <= bus_wdata[7:3];
                    prc_regs_pkg::reg_map_base_mid_addr:
                        map_base_q[15:8] <= bus_wdata;
                    prc_regs_pkg::reg_map_base_hi_addr:
                        map_base_q[20:16] <= bus_wdata[4:0];
                    prc_regs_pkg::reg_scroll_y_addr:
                        if (bus_wdata <= scroll_y_limit)
                            scroll_y_q <= bus_wdata[6:0];
                    prc_regs_pkg::reg_scroll_x_addr:
                        if (bus_wdata <= scroll_x_limit)
                            scroll_x_q <= bus_wdata[6:0];
                    default:
                    begin
                    end
                endcase
            end
        end
    end

    always_comb
    begin
        case (bus_address)
            prc_regs_pkg::reg_mode_addr:         bus_rdata = {2'b00, mode_q};
            prc_regs_pkg::reg_rate_addr:         bus_rdata = {skip_count, rate_q};
            prc_regs_pkg::reg_map_base_lo_addr:  bus_rdata = {map_base_q[7:3], 3'b000};
            prc_regs_pkg::reg_map_base_mid_addr: bus_rdata = map_base_q[15:8];
            prc_regs_pkg::reg_map_base_hi_addr:  bus_rdata = {3'b000, map_base_q[20:16]};
            prc_regs_pkg::reg_scroll_y_addr:     bus_rdata = {1'b0, scroll_y_q};
            prc_regs_pkg::reg_scroll_x_addr:     bus_rdata = {1'b0, scroll_x_q};
            prc_regs_pkg::reg_counter_addr:      bus_rdata = {1'b0, frame_count};
            default:                             bus_rdata = '0;
        endcase
    end

    assign cfg = '{
        mode:         mode_q,
        rate_sel:     rate_q[3:1],
        map_base:     {map_base_q, 3'b000},
        scroll_y:     scroll_y_q,
        scroll_x:     scroll_x_q,
        rate_changed: rate_changed
    };

endmodule

`default_nettype wire

//--- design/prc_frame_timer.sv
`timescale 1ns/1ps
`default_nettype none

module prc_frame_timer
#(
    parameter int osc_divide = prc_video_pkg::default_osc_divide
)
(
    input  wire                                   clk,
    input  wire                                   reset,
    input  wire prc_regs_pkg::prc_config_t        cfg,
    output logic [prc_regs_pkg::count_width-1:0]  frame_count,
    output logic [prc_regs_pkg::skip_width-1:0]   skip_count,
    output logic                                  render_start,
    output logic                                  irq_render_done
);

    logic [$clog2(osc_divide)-1:0] div_count;
    logic                          tick_end;
    logic                          active;
    logic                          last_tick;

    assign tick_end  = (int'(div_count) == osc_divide - 1);
    assign active    = (skip_count == prc_video_pkg::rate_match_of[cfg.rate_sel]);
    assign last_tick = (int'(frame_count) == prc_video_pkg::frame_ticks);

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            div_count       <= '0;
            frame_count     <= 7'd1;
            skip_count      <= '0;
            render_start    <= 1'b0;
            irq_render_done <= 1'b0;
        end
        else
        begin
            render_start    <= 1'b0;
            irq_render_done <= 1'b0;
            div_count       <= tick_end ? '0 : div_count + 1'b1;

            if (tick_end)
            begin
                frame_count <= last_tick ? 7'd1 : frame_count + 7'd1;

                // counter is about to reach the render start tick
                if (int'(frame_count) == prc_video_pkg::render_start_tick - 1)
                    render_start <= active && cfg.mode[1];

                if (last_tick)
                begin
                    if (active)
                    begin
                        irq_render_done <= 1'b1;
                        skip_count      <= '0;
                    end
                    else
                        skip_count <= skip_count + 1'b1;   // skipped frame
                end
            end

            if (cfg.rate_changed)
                skip_count <= '0;
        end
    end

endmodule

`default_nettype wire

//--- design/prc_map_renderer.sv
`timescale 1ns/1ps
`default_nettype none

module prc_map_renderer
(
    input  wire                            clk,
    input  wire                            reset,
    input  wire prc_regs_pkg::prc_config_t cfg,
    input  wire                            render_start,
    prc_mem_bus_if.master                  mem
);

    // three accesses per vram byte
    typedef enum logic [1:0] {st_idle, st_map, st_tile, st_write} state_t;

    state_t               state;
    logic [6:0]           xc;
    logic [2:0]           yc;
    logic [6:0]           next_xc;
    logic [2:0]           next_yc;
    logic [7:0]           next_mx;    // map pixel column
    logic [4:0]           next_my;    // map tile row
    logic [2:0]           tile_col;
    logic                 last_col;
    logic                 done;
    prc_video_pkg::addr_t map_width;
    prc_video_pkg::addr_t map_addr;

    always_comb
    begin
        last_col = (xc == 7'(prc_video_pkg::screen_columns - 1));
        done     = last_col && (yc == 3'(prc_video_pkg::screen_pages - 1));
        if (state == st_idle)
        begin
            next_xc = '0;
            next_yc = '0;
        end
        else if (last_col)
        begin
            next_xc = '0;
            next_yc = yc + 3'd1;
        end
        else
        begin
            next_xc = xc + 7'd1;
            next_yc = yc;
        end
        next_mx   = {1'b0, next_xc} + {1'b0, cfg.scroll_x};
        next_my   = {2'b00, next_yc} + {1'b0, cfg.scroll_y[6:3]};   // whole tile rows only
        map_width = prc_video_pkg::addr_t'(prc_regs_pkg::map_width_of[cfg.mode[5:4]]);
        map_addr  = prc_video_pkg::tilemap_base + prc_video_pkg::addr_t'(next_my) * map_width
                  + prc_video_pkg::addr_t'(next_mx[7:3]);
        tile_col  = xc[2:0] + cfg.scroll_x[2:0];
    end

    assign mem.valid = (state != st_idle);   // also the busy flag
    assign mem.write = (state == st_write);

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            state <= st_idle;
            xc    <= '0;
            yc    <= '0;
        end
        else
        begin
            case (state)
                st_idle:
                    if (render_start)
                    begin
                        state <= st_map;
                        xc    <= '0;
                        yc    <= '0;
                    end
                st_map:
                    if (mem.ready)
                        state <= st_tile;
                st_tile:
                    if (mem.ready)
                        state <= st_write;
                st_write:
                    if (mem.ready)
                    begin
                        xc    <= next_xc;
                        yc    <= next_yc;
                        state <= done ? st_idle : st_map;
                    end
            endcase
        end
    end

    // request payload only moves on a handshake
    always_ff @(posedge clk)
    begin
        case (state)
            st_idle:
                mem.address <= map_addr;
            st_map:
                if (mem.ready)
                    mem.address <= prc_video_pkg::addr_t'(cfg.map_base)
                                 + prc_video_pkg::addr_t'({mem.rdata, 3'b000})
                                 + prc_video_pkg::addr_t'(tile_col);
            st_tile:
                if (mem.ready)
                begin
                    mem.wdata   <= mem.rdata;
                    mem.address <= prc_video_pkg::vram_base
                                 + prc_video_pkg::addr_t'(yc)
                                 * prc_video_pkg::addr_t'(prc_video_pkg::screen_columns)
                                 + prc_video_pkg::addr_t'(xc);
                end
            st_write:
                if (mem.ready)
                    mem.address <= map_addr;
        endcase
    end

endmodule

`default_nettype wire

//--- design/prc_top.sv
`timescale 1ns/1ps
`default_nettype none

module prc_top
#(
    parameter int osc_divide = prc_video_pkg::default_osc_divide
)
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        bus_write,
    input  wire prc_video_pkg::addr_t  bus_address,
    input  wire prc_video_pkg::data_t  bus_wdata,
    output prc_video_pkg::data_t       bus_rdata,
    output logic                       mem_valid,
    input  wire                        mem_ready,
    output logic                       mem_write,
    output prc_video_pkg::addr_t       mem_address,
    output prc_video_pkg::data_t       mem_wdata,
    input  wire prc_video_pkg::data_t  mem_rdata,
    output logic                       irq_render_done
);

    prc_regs_pkg::prc_config_t            cfg;
    logic [prc_regs_pkg::count_width-1:0] frame_count;
    logic [prc_regs_pkg::skip_width-1:0]  skip_count;
    logic                                 render_start;

    prc_mem_bus_if mem_bus ();

    // memory bus out to the pins
    assign mem_valid     = mem_bus.valid;
    assign mem_write     = mem_bus.write;
    assign mem_address   = mem_bus.address;
    assign mem_wdata     = mem_bus.wdata;
    assign mem_bus.ready = mem_ready;
    assign mem_bus.rdata = mem_rdata;

    prc_registers i_registers
    (
        .clk         (clk),
        .reset       (reset),
        .bus_write   (bus_write),
        .bus_address (bus_address),
        .bus_wdata   (bus_wdata),
        .frame_count (frame_count),
        .skip_count  (skip_count),
        .bus_rdata   (bus_rdata),
        .cfg         (cfg)
    );

    prc_frame_timer #(.osc_divide(osc_divide)) i_frame_timer
    (
        .clk             (clk),
        .reset           (reset),
        .cfg             (cfg),
        .frame_count     (frame_count),
        .skip_count      (skip_count),
        .render_start    (render_start),
        .irq_render_done (irq_render_done)
    );

    prc_map_renderer i_map_renderer
    (
        .clk          (clk),
        .reset        (reset),
        .cfg          (cfg),
        .render_start (render_start),
        .mem          (mem_bus)
    );

endmodule

`default_nettype wire

//--- verification/prc_checker.sv
`timescale 1ns/1ps
`default_nettype none

module prc_checker
#(
    parameter int osc_divide = 128,
    parameter int fill_seed  = 32'had6c8ea1
)
(
    input  wire         clk,
    input  wire         reset,
    input  wire         bus_write,
    input  wire [23:0]  bus_address,
    input  wire [7:0]   bus_wdata,
    input  wire [7:0]   bus_rdata,
    input  wire         mem_valid,
    input  wire         mem_ready,
    input  wire         mem_write,
    input  wire [23:0]  mem_address,
    input  wire [7:0]   mem_wdata,
    input  wire         irq_render_done,
    input  wire         expect_valid,
    input  wire [7:0]   expect_data,
    input  wire [7:0]   expect_mask,
    output int          error_count,
    output int          frames_done
);

    // map size in tiles by mode bits 5:4, and active skip count by rate select
    localparam int map_widths   [4] = '{12, 16, 24, 24};
    localparam int map_heights  [4] = '{16, 12, 8, 16};
    localparam int rate_matches [8] = '{2, 5, 8, 11, 1, 3, 5, 7};

    logic [7:0]  mem_copy [0:65535];   // same fill as the memory model
    logic [5:0]  mode_s;
    logic [2:0]  rate_sel_s;
    logic [20:0] base_s;
    logic [6:0]  scroll_y_s;
    logic [6:0]  scroll_x_s;
    int          writes;
    int          gap_cycles;         // cycles since the last interrupt
    logic        irq_armed;
    logic        stall_q;
    logic [23:0] addr_q;
    logic        write_q;
    logic [7:0]  wdata_q;
    logic [7:0]  count_q;
    logic        count_valid;

    initial
    begin
        integer seed;
        seed = fill_seed;
        for (int a = 0; a < 65536; a++)
            mem_copy[a] = 8'($random(seed));
    end

    // tilemap rule for vram byte n
    function automatic logic [7:0] expected_pixel(input int n);
        int   xc;
        int   yc;
        int   mx;
        int   my;
        int   width;
        logic [7:0] tile;
        xc    = n % 96;
        yc    = n / 96;
        mx    = xc + int'(scroll_x_s);
        my    = yc + int'(scroll_y_s) / 8;
        width = map_widths[mode_s[5:4]];
        tile  = mem_copy[(32'h1360 + my * width + mx / 8) & 32'hffff];
        return mem_copy[(int'(base_s) + int'(tile) * 8 + mx % 8) & 32'hffff];
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("ERROR %0t %s expected %0h got %0h", $time, name, exp, act);
        error_count++;
    endtask

    always @(posedge clk)
    begin
        int height;
        int width;
        int period;
        if (reset)
        begin
            mode_s      <= '0;
            rate_sel_s  <= '0;
            base_s      <= '0;
            scroll_y_s  <= '0;
            scroll_x_s  <= '0;
            writes      <= 0;
            gap_cycles  <= 0;
            irq_armed   <= 1'b0;
            stall_q     <= 1'b0;
            count_valid <= 1'b0;
        end
        else
        begin
            height = map_heights[mode_s[5:4]];
            width  = map_widths[mode_s[5:4]];
            if (bus_write)
            begin
                case (bus_address)
                    24'h2080: mode_s <= bus_wdata[5:0];
                    24'h2081:
                    begin
                        rate_sel_s <= bus_wdata[3:1];
                        irq_armed  <= 1'b0;     // skip count restarts
                    end
                    24'h2082: base_s[7:3]   <= bus_wdata[7:3];
                    24'h2083: base_s[15:8]  <= bus_wdata;
                    24'h2084: base_s[20:16] <= bus_wdata[4:0];
                    24'h2085:
                        if (int'(bus_wdata) <= height * 8 - 64)
                            scroll_y_s <= bus_wdata[6:0];
                    24'h2086:
                        if (int'(bus_wdata) <= width * 8 - 96)
                            scroll_x_s <= bus_wdata[6:0];
                    default:
                    begin
                    end
                endcase
            end

            if (expect_valid && ((bus_rdata & expect_mask) !== (expect_data & expect_mask)))
                report_mismatch("bus_rdata", expect_data & expect_mask, bus_rdata & expect_mask);

            // frame counter readback only moves forward or wraps
            if (!bus_write && bus_address == 24'h208A)
            begin
                if (bus_rdata < 8'd1 || bus_rdata > 8'd66)
                begin
                    $display("frame counter read back %0d outside 1 to 66 at %0t",
                             bus_rdata, $time);
                    error_count++;
                end
                else if (count_valid && bus_rdata < count_q
                         && !(count_q == 8'd66 && bus_rdata == 8'd1))
                    report_mismatch("bus_rdata counter order", count_q, bus_rdata);
                count_q     <= bus_rdata;
                count_valid <= 1'b1;
            end
            else
                count_valid <= 1'b0;

            if (mem_valid && !mode_s[1])
            begin
                $display("memory access at %0t while the map is disabled", $time);
                error_count++;
            end

            if (stall_q && mem_address !== addr_q)
                report_mismatch("mem_address held", addr_q, mem_address);
            if (stall_q && mem_write !== write_q)
                report_mismatch("mem_write held", write_q, mem_write);
            if (stall_q && mem_wdata !== wdata_q)
                report_mismatch("mem_wdata held", wdata_q, mem_wdata);
            stall_q <= mem_valid && !mem_ready;
            addr_q  <= mem_address;
            write_q <= mem_write;
            wdata_q <= mem_wdata;

            if (mem_valid && mem_ready && mem_write)
            begin
                if (writes >= 768)
                begin
                    $display("more than 768 vram writes in one frame at %0t", $time);
                    error_count++;
                end
                else
                begin
                    if (mem_address !== 24'h1000 + 24'(writes))
                        report_mismatch("mem_address", 24'h1000 + writes, mem_address);
                    if (mem_wdata !== expected_pixel(writes))
                        report_mismatch("mem_wdata", expected_pixel(writes), mem_wdata);
                end
                mem_copy[mem_address[15:0]] <= mem_wdata;
                writes <= writes + 1;
            end

            gap_cycles <= gap_cycles + 1;
            if (irq_render_done)
            begin
                if (writes != (mode_s[1] ? 768 : 0))
                    report_mismatch("vram write count", mode_s[1] ? 768 : 0, writes);
                else if (mode_s[1])
                    frames_done++;
                period = (rate_matches[rate_sel_s] + 1) * 66 * osc_divide;
                if (irq_armed && gap_cycles + 1 != period)
                    report_mismatch("irq_render_done interval", period, gap_cycles + 1);
                writes     <= 0;
                gap_cycles <= 0;
                irq_armed  <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_prc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_prc;

    localparam int osc_divide = 128;
    localparam int n_entries  = 35;
    localparam int rate_match = 1;    // rate select 4

    // address, write data, expected readback, compare mask
    localparam logic [47:0] stim_table [n_entries] = '{
        {24'h2080, 8'hFD, 8'h3D, 8'hFF}, {24'h2081, 8'hF5, 8'h05, 8'h0F},
        {24'h2082, 8'hFF, 8'hF8, 8'hFF}, {24'h2083, 8'hA5, 8'hA5, 8'hFF},
        {24'h2084, 8'hFF, 8'h1F, 8'hFF}, {24'h2087, 8'h55, 8'h00, 8'hFF},
        {24'h208B, 8'h55, 8'h00, 8'hFF}, {24'h2080, 8'h31, 8'h31, 8'hFF},
        {24'h2085, 8'h41, 8'h00, 8'hFF}, {24'h2085, 8'h40, 8'h40, 8'hFF},
        {24'h2086, 8'h61, 8'h00, 8'hFF}, {24'h2086, 8'h60, 8'h60, 8'hFF},
        {24'h2080, 8'h01, 8'h01, 8'hFF}, {24'h2086, 8'h01, 8'h60, 8'hFF},
        {24'h2086, 8'h00, 8'h00, 8'hFF}, {24'h2085, 8'h3F, 8'h3F, 8'hFF},
        {24'h2085, 8'h41, 8'h3F, 8'hFF}, {24'h2085, 8'h40, 8'h40, 8'hFF},
        {24'h2080, 8'h11, 8'h11, 8'hFF}, {24'h2085, 8'h21, 8'h40, 8'hFF},
        {24'h2085, 8'h20, 8'h20, 8'hFF}, {24'h2086, 8'h21, 8'h00, 8'hFF},
        {24'h2086, 8'h20, 8'h20, 8'hFF}, {24'h2080, 8'h21, 8'h21, 8'hFF},
        {24'h2085, 8'h01, 8'h20, 8'hFF}, {24'h2085, 8'h00, 8'h00, 8'hFF},
        {24'h2086, 8'h61, 8'h20, 8'hFF}, {24'h2086, 8'h60, 8'h60, 8'hFF},
        {24'h208A, 8'h00, 8'h01, 8'hFF}, {24'h2082, 8'h00, 8'h00, 8'hFF},
        {24'h2083, 8'h40, 8'h40, 8'hFF}, {24'h2084, 8'h00, 8'h00, 8'hFF},
        {24'h2080, 8'h01, 8'h01, 8'hFF}, {24'h2086, 8'h00, 8'h00, 8'hFF},
        {24'h2085, 8'h18, 8'h18, 8'hFF}
    };

    localparam int cycle_limit = 3 * 66 * osc_divide * (rate_match + 1) + n_entries * 3 + 16;

    logic        clk;
    logic        reset;
    logic        bus_write;
    logic [23:0] bus_address;
    logic [7:0]  bus_wdata;
    logic [7:0]  bus_rdata;
    logic        mem_valid;
    logic        mem_ready;
    logic        mem_write;
    logic [23:0] mem_address;
    logic [7:0]  mem_wdata;
    logic [7:0]  mem_rdata;
    logic        irq_render_done;
    logic        expect_valid;
    logic [7:0]  expect_data;
    logic [7:0]  expect_mask;
    int          error_count;
    int          frames_done;
    int          cycles;
    integer      seed;
    logic [7:0]  mem [0:65535];

    prc_top #(.osc_divide(osc_divide)) i_dut
    (
        .clk             (clk),
        .reset           (reset),
        .bus_write       (bus_write),
        .bus_address     (bus_address),
        .bus_wdata       (bus_wdata),
        .bus_rdata       (bus_rdata),
        .mem_valid       (mem_valid),
        .mem_ready       (mem_ready),
        .mem_write       (mem_write),
        .mem_address     (mem_address),
        .mem_wdata       (mem_wdata),
        .mem_rdata       (mem_rdata),
        .irq_render_done (irq_render_done)
    );

    prc_checker #(.osc_divide(osc_divide), .fill_seed(32'had6c8ea1)) i_checker
    (
        .clk (clk), .reset (reset), .bus_write (bus_write), .bus_address (bus_address),
        .bus_wdata (bus_wdata), .bus_rdata (bus_rdata), .mem_valid (mem_valid),
        .mem_ready (mem_ready), .mem_write (mem_write), .mem_address (mem_address),
        .mem_wdata (mem_wdata), .irq_render_done (irq_render_done),
        .expect_valid (expect_valid), .expect_data (expect_data),
        .expect_mask (expect_mask), .error_count (error_count), .frames_done (frames_done)
    );

    always #10 clk = ~clk;

    // memory model, read data follows the address
    assign mem_rdata = mem[mem_address[15:0]];

    always @(posedge clk)
    begin
        if (mem_valid && mem_ready && mem_write)
            mem[mem_address[15:0]] <= mem_wdata;
        #2 mem_ready <= (($random(seed) & 3) != 0);   // high three cycles in four
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > cycle_limit)
        begin
            $display("timeout after %0d cycles, %0d frames rendered", cycles, frames_done);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic write_reg(input logic [23:0] addr, input logic [7:0] data);
        @(posedge clk);
        #2;
        bus_write   = 1'b1;
        bus_address = addr;
        bus_wdata   = data;
        @(posedge clk);
        #2;
        bus_write = 1'b0;
    endtask

    initial
    begin
        clk          = 1'b0;
        reset        = 1'b1;
        bus_write    = 1'b0;
        bus_address  = '0;
        bus_wdata    = '0;
        mem_ready    = 1'b0;
        expect_valid = 1'b0;
        expect_data  = '0;
        expect_mask  = '0;
        cycles       = 0;
        seed         = 32'had6c8ea1;
        for (int a = 0; a < 65536; a++)
            mem[a] = 8'($random(seed));
        repeat (16) @(posedge clk);
        #2 reset = 1'b0;

        for (int i = 0; i < n_entries; i++)
        begin
            write_reg(stim_table[i][47:24], stim_table[i][23:16]);
            expect_valid = 1'b1;   // compared at the next edge
            expect_data  = stim_table[i][15:8];
            expect_mask  = stim_table[i][7:0];
            @(posedge clk);
            #2 expect_valid = 1'b0;
        end

        // mode bit 1 still clear, so the first active frame renders nothing
        write_reg(24'h2081, 8'h08);
        bus_address = 24'h208A;
        while (!irq_render_done)
        begin
            @(posedge clk);
            #2;
        end

        write_reg(24'h2080, 8'h02);
        bus_address = 24'h208A;
        while (frames_done < 2)
            @(posedge clk);

        $display("errors: %0d, frames checked: %0d", error_count, frames_done);
        if (error_count == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
design/prc_regs_pkg.sv
design/prc_video_pkg.sv
design/prc_mem_bus_if.sv
design/prc_registers.sv
design/prc_frame_timer.sv
design/prc_map_renderer.sv
design/prc_top.sv
verification/prc_checker.sv
verification/tb_prc.sv

//--- Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f files.f --top-module tb_prc -o Vtb_prc

run: build
	./obj_dir/Vtb_prc | tee sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module tb_prc

clean:
	rm -rf obj_dir sim.log
